/* src/datapathPkg.sv */
package datapathPkg;

    localparam int dataWidth    = 32;
    localparam int numRegs      = 16;
    localparam int regIdxWidth  = 4;
    localparam int memDepth     = 512;
    localparam int memAddrWidth = 9;
    localparam int opWidth      = 5;
    localparam int condWidth    = 2;
    localparam int constWidth   = 19;
    localparam int shamtWidth   = $clog2(dataWidth);

    // ALU opcodes
    localparam logic [opWidth-1:0] opAdd  = 5'd3;
    localparam logic [opWidth-1:0] opSub  = 5'd4;
    localparam logic [opWidth-1:0] opShr  = 5'd5;
    localparam logic [opWidth-1:0] opShra = 5'd6;
    localparam logic [opWidth-1:0] opShl  = 5'd7;
    localparam logic [opWidth-1:0] opRor  = 5'd8;
    localparam logic [opWidth-1:0] opRol  = 5'd9;
    localparam logic [opWidth-1:0] opAnd  = 5'd10;
    localparam logic [opWidth-1:0] opOr   = 5'd11;
    localparam logic [opWidth-1:0] opMul  = 5'd15;
    localparam logic [opWidth-1:0] opDiv  = 5'd16;
    localparam logic [opWidth-1:0] opNeg  = 5'd17;
    localparam logic [opWidth-1:0] opNot  = 5'd18;

    // Branch conditions, IR bits 20..19
    localparam logic [condWidth-1:0] condZero     = 2'b00;
    localparam logic [condWidth-1:0] condNonZero  = 2'b01;
    localparam logic [condWidth-1:0] condPositive = 2'b10;
    localparam logic [condWidth-1:0] condNegative = 2'b11;

    typedef union packed {
        struct packed {
            logic [opWidth-1:0]     opcode;
            logic [regIdxWidth-1:0] ra;
            logic [regIdxWidth-1:0] rb;
            logic [regIdxWidth-1:0] rc;
            logic [14:0]            unused;
        } regForm;
        struct packed {
            logic [opWidth-1:0]     opcode;
            logic [regIdxWidth-1:0] ra;
            logic [regIdxWidth-1:0] rb;
            logic [constWidth-1:0]  constant;
        } immForm;
        struct packed {
            logic [opWidth-1:0]     opcode;
            logic [regIdxWidth-1:0] ra;
            logic [1:0]             spare;
            logic [condWidth-1:0]   cond;
            logic [constWidth-1:0]  constant;
        } branchForm;
    } instrWord;

endpackage

/* src/gpRegister.sv */
`timescale 1ns/1ns

module gpRegister import datapathPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 load,
    input  logic                 drive,
    input  logic [dataWidth-1:0] busValue,
    output logic [dataWidth-1:0] busLeg
);

    logic [dataWidth-1:0] value;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            value <= '0;
        end else if (load) begin
            value <= busValue;
        end
    end

    // Zero when not driving so the legs can be ORed
    assign busLeg = drive ? value : '0;

endmodule

/* src/selectEncode.sv */
`timescale 1ns/1ns

module selectEncode import datapathPkg::*; (
    input  instrWord             ir,
    input  logic                 gra,
    input  logic                 grb,
    input  logic                 grc,
    input  logic                 rIn,
    input  logic                 rOut,
    input  logic                 baOut,
    output logic [numRegs-1:0]   regLoad,
    output logic [numRegs-1:0]   regDrive,
    output logic                 zeroR0,
    output logic [dataWidth-1:0] cSignExt
);

    logic [regIdxWidth-1:0] regSel;
    logic [numRegs-1:0]     oneHot;
    logic                   anyDrive;

    // Field pick, only one of gra/grb/grc expected
    assign regSel = ({regIdxWidth{gra}} & ir.regForm.ra)
                  | ({regIdxWidth{grb}} & ir.regForm.rb)
                  | ({regIdxWidth{grc}} & ir.regForm.rc);

    assign oneHot = {{(numRegs-1){1'b0}}, 1'b1} << regSel;

    assign anyDrive = rOut | baOut;

    assign regLoad  = rIn ? oneHot : '0;
    assign regDrive = anyDrive ? oneHot : '0;

    // R0 reads as zero only when used as a base address
    assign zeroR0 = baOut && (regSel == '0);

    assign cSignExt = {{(dataWidth-constWidth){ir.immForm.constant[constWidth-1]}},
                       ir.immForm.constant};

endmodule

/* src/busMux.sv */
`timescale 1ns/1ns

module busMux import datapathPkg::*; (
    input  logic [dataWidth-1:0]   regLegs [numRegs],
    input  logic                   zeroR0,
    input  logic                   hiOut,
    input  logic                   loOut,
    input  logic                   zHighOut,
    input  logic                   zLowOut,
    input  logic                   pcOut,
    input  logic                   mdrOut,
    input  logic                   inPortOut,
    input  logic                   cOut,
    input  logic [dataWidth-1:0]   hiValue,
    input  logic [dataWidth-1:0]   loValue,
    input  logic [2*dataWidth-1:0] zValue,
    input  logic [dataWidth-1:0]   pcValue,
    input  logic [dataWidth-1:0]   mdrValue,
    input  logic [dataWidth-1:0]   inPortValue,
    input  logic [dataWidth-1:0]   cSignExt,
    output logic [dataWidth-1:0]   busValue
);

    logic [dataWidth-1:0] regOr;
    logic [dataWidth-1:0] specialOr;

    // Legs are already gated by their drive strobes
    always_comb begin
        regOr = zeroR0 ? '0 : regLegs[0];
        for (int i = 1; i < numRegs; i++) begin
            regOr = regOr | regLegs[i];
        end
    end

    assign specialOr = ({dataWidth{hiOut}}     & hiValue)
                     | ({dataWidth{loOut}}     & loValue)
                     | ({dataWidth{zHighOut}}  & zValue[2*dataWidth-1:dataWidth])
                     | ({dataWidth{zLowOut}}   & zValue[dataWidth-1:0])
                     | ({dataWidth{pcOut}}     & pcValue)
                     | ({dataWidth{mdrOut}}    & mdrValue)
                     | ({dataWidth{inPortOut}} & inPortValue)
                     | ({dataWidth{cOut}}      & cSignExt);

    // Idle bus is zero, overlapping drivers OR together
    assign busValue = regOr | specialOr;

endmodule

/* src/alu.sv */
`timescale 1ns/1ns

module alu import datapathPkg::*; (
    input  logic [opWidth-1:0]     opcode,
    input  logic [dataWidth-1:0]   a,      // From Y
    input  logic [dataWidth-1:0]   b,      // From the bus
    output logic [2*dataWidth-1:0] result
);

    logic [shamtWidth-1:0]         shamt;
    logic [2*dataWidth-1:0]        doubled;
    logic [2*dataWidth-1:0]        rorWide;
    logic [2*dataWidth-1:0]        rolWide;
    logic signed [2*dataWidth-1:0] product;
    logic signed [dataWidth-1:0]   quotient;
    logic signed [dataWidth-1:0]   remainder;
    logic                          divByZero;

    assign shamt   = b[shamtWidth-1:0];
    assign doubled = {a, a};

    // Rotates come out of a doubled word
    assign rorWide = doubled >> shamt;
    assign rolWide = doubled << shamt;

    // Operands sign-extended to the full product width
    assign product = $signed({{dataWidth{a[dataWidth-1]}}, a})
                   * $signed({{dataWidth{b[dataWidth-1]}}, b});

    assign divByZero = (b == '0);

    // Signed quotient and remainder, divider forced to one on zero
    assign quotient  = $signed(a) / $signed(divByZero ? {{(dataWidth-1){1'b0}}, 1'b1} : b);
    assign remainder = $signed(a) % $signed(divByZero ? {{(dataWidth-1){1'b0}}, 1'b1} : b);

    always_comb begin
        result = '0;
        case (opcode)
            opAdd:   result[dataWidth-1:0] = a + b;
            opSub:   result[dataWidth-1:0] = a - b;
            opAnd:   result[dataWidth-1:0] = a & b;
            opOr:    result[dataWidth-1:0] = a | b;
            opShr:   result[dataWidth-1:0] = a >> shamt;
            opShra:  result[dataWidth-1:0] = $signed(a) >>> shamt;
            opShl:   result[dataWidth-1:0] = a << shamt;
            opRor:   result[dataWidth-1:0] = rorWide[dataWidth-1:0];
            opRol:   result[dataWidth-1:0] = rolWide[2*dataWidth-1:dataWidth];
            opNeg:   result[dataWidth-1:0] = -b;
            opNot:   result[dataWidth-1:0] = ~b;
            opMul: begin
                result = product;
            end
            opDiv: begin
                if (divByZero) begin
                    result = {a, {dataWidth{1'b1}}};  // All ones low, dividend high
                end else begin
                    result = {remainder, quotient};
                end
            end
            default: result = '0;
        endcase
    end

endmodule

/* src/branchCondition.sv */
`timescale 1ns/1ns

module branchCondition import datapathPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 conIn,
    input  instrWord             ir,
    input  logic [dataWidth-1:0] busValue,
    output logic                 branchTaken
);

    logic isZero;
    logic condMet;

    assign isZero = (busValue == '0);

    always_comb begin
        case (ir.branchForm.cond)
            condZero:     condMet = isZero;
            condNonZero:  condMet = !isZero;
            condPositive: condMet = !busValue[dataWidth-1] && !isZero;  // Strictly positive
            condNegative: condMet = busValue[dataWidth-1];
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            branchTaken <= 1'b0;
        end else if (conIn) begin
            branchTaken <= condMet;
        end
    end

endmodule

/* src/memoryPort.sv */
`timescale 1ns/1ns

module memoryPort import datapathPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    mdrIn,
    input  logic                    memRead,
    input  logic                    memWrite,
    input  logic [memAddrWidth-1:0] marValue,
    input  logic [dataWidth-1:0]    busValue,
    output logic [dataWidth-1:0]    mdrValue
);

    logic [dataWidth-1:0] mem [memDepth];
    logic [dataWidth-1:0] mdrNext;

    // Memory word on a read, bus otherwise
    assign mdrNext = memRead ? mem[marValue] : busValue;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            mdrValue <= '0;
        end else if (mdrIn) begin
            mdrValue <= mdrNext;
        end
    end

    always_ff @(posedge clk) begin
        if (memWrite) begin
            mem[marValue] <= mdrValue;  // Written from MDR
        end
    end

endmodule

/* src/datapath.sv */
`timescale 1ns/1ns

module datapath import datapathPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 gra, grb, grc,
    input  logic                 rIn, rOut, baOut,
    input  logic                 hiIn, loIn, zIn, pcIn, irIn, yIn, marIn, mdrIn,
    input  logic                 outPortIn, inPortIn, conIn,
    input  logic                 hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut,
    input  logic                 inPortOut, cOut,
    input  logic                 memRead, memWrite,
    input  logic [opWidth-1:0]   opcode,
    input  logic [dataWidth-1:0] inData,
    output logic [dataWidth-1:0] busValue,
    output logic [dataWidth-1:0] outPortData,
    output logic                 branchTaken
);

    logic [dataWidth-1:0]    regLegs [numRegs];
    logic [numRegs-1:0]      regLoad;
    logic [numRegs-1:0]      regDrive;
    logic                    zeroR0;
    logic [dataWidth-1:0]    cSignExt;
    logic [dataWidth-1:0]    hiReg, loReg, pcReg, yReg, inPortReg;
    logic [2*dataWidth-1:0]  zReg;
    logic [2*dataWidth-1:0]  aluResult;
    logic [memAddrWidth-1:0] marReg;
    logic [dataWidth-1:0]    mdrValue;
    instrWord                irReg;

    for (genvar i = 0; i < numRegs; i++) begin : gRegs
        gpRegister i_gpRegister (
            .clk, .rstN,
            .load(regLoad[i]), .drive(regDrive[i]),
            .busValue, .busLeg(regLegs[i])
        );
    end

    // Special registers
    always_ff @(posedge clk) begin
        if (!rstN) begin
            hiReg       <= '0;
            loReg       <= '0;
            zReg        <= '0;
            pcReg       <= '0;
            irReg       <= '0;
            yReg        <= '0;
            marReg      <= '0;
            inPortReg   <= '0;
            outPortData <= '0;
        end else begin
            if (hiIn)      hiReg       <= busValue;
            if (loIn)      loReg       <= busValue;
            if (zIn)       zReg        <= aluResult;  // Y op bus
            if (pcIn)      pcReg       <= busValue;
            if (irIn)      irReg       <= busValue;
            if (yIn)       yReg        <= busValue;
            if (marIn)     marReg      <= busValue[memAddrWidth-1:0];
            if (inPortIn)  inPortReg   <= inData;
            if (outPortIn) outPortData <= busValue;
        end
    end

    selectEncode i_selectEncode (
        .ir(irReg), .gra, .grb, .grc, .rIn, .rOut, .baOut,
        .regLoad, .regDrive, .zeroR0, .cSignExt
    );

    busMux i_busMux (
        .regLegs, .zeroR0,
        .hiOut, .loOut, .zHighOut, .zLowOut, .pcOut, .mdrOut, .inPortOut, .cOut,
        .hiValue(hiReg), .loValue(loReg), .zValue(zReg), .pcValue(pcReg),
        .mdrValue, .inPortValue(inPortReg), .cSignExt, .busValue
    );

    alu i_alu (.opcode, .a(yReg), .b(busValue), .result(aluResult));

    branchCondition i_branchCondition (
        .clk, .rstN, .conIn, .ir(irReg), .busValue, .branchTaken
    );

    memoryPort i_memoryPort (
        .clk, .rstN, .mdrIn, .memRead, .memWrite,
        .marValue(marReg), .busValue, .mdrValue
    );

endmodule

/* dv/datapathTb.sv */
`timescale 1ns/1ns

module datapathTb import datapathPkg::*; ();

    localparam int    maxSteps = 256;
    localparam string stimFile = "dv/datapathStimulus.txt";

    logic                 clk;
    logic                 rstN;
    logic                 gra, grb, grc, rIn, rOut, baOut;
    logic                 hiIn, loIn, zIn, pcIn, irIn, yIn, marIn, mdrIn;
    logic                 outPortIn, inPortIn, conIn;
    logic                 hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut, inPortOut, cOut;
    logic                 memRead, memWrite;
    logic [opWidth-1:0]   opcode;
    logic [dataWidth-1:0] inData;
    logic [dataWidth-1:0] busValue;
    logic [dataWidth-1:0] outPortData;
    logic                 branchTaken;

    // One entry per control step
    logic [5:0]           selVec    [maxSteps];
    logic [10:0]          loadVec   [maxSteps];
    logic [7:0]           driveVec  [maxSteps];
    logic [1:0]           memVec    [maxSteps];
    logic [opWidth-1:0]   opVec     [maxSteps];
    logic [dataWidth-1:0] dataVec   [maxSteps];
    logic [2:0]           maskVec   [maxSteps];  // Bus, out port, branch
    logic [dataWidth-1:0] expBus    [maxSteps];
    logic [dataWidth-1:0] expOut    [maxSteps];
    logic                 expBranch [maxSteps];

    int stepCount   = 0;
    int checkErrors = 0;
    int fileErrors  = 0;
    int cycleCount  = 0;
    int cycleLimit  = maxSteps + 20;

    datapath i_datapath (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles, the step sequence never finished", cycleCount);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic applyStep(input int s);
        {gra, grb, grc, rIn, rOut, baOut} = selVec[s];
        {hiIn, loIn, zIn, pcIn, irIn, yIn, marIn, mdrIn, outPortIn, inPortIn, conIn} = loadVec[s];
        {hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut, inPortOut, cOut} = driveVec[s];
        {memRead, memWrite} = memVec[s];
        opcode = opVec[s];
        inData = dataVec[s];
    endtask

    task automatic clearInputs;
        {gra, grb, grc, rIn, rOut, baOut} = '0;
        {hiIn, loIn, zIn, pcIn, irIn, yIn, marIn, mdrIn, outPortIn, inPortIn, conIn} = '0;
        {hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut, inPortOut, cOut} = '0;
        {memRead, memWrite} = '0;
        opcode = '0;
        inData = '0;
    endtask

    task automatic loadStimulus;
        int                   fd;
        int                   n;
        string                line;
        logic [5:0]           sel;
        logic [10:0]          load;
        logic [7:0]           drive;
        logic [1:0]           mem;
        logic [opWidth-1:0]   op;
        logic [dataWidth-1:0] data;
        logic [2:0]           mask;
        logic [dataWidth-1:0] eBus;
        logic [dataWidth-1:0] eOut;
        logic                 eBranch;
        fd = $fopen(stimFile, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %s", stimFile);
            fileErrors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n <= 0 || line.len() < 2 || line[0] == "#") continue;  // Blank or comment
            if (stepCount >= maxSteps) begin
                $display("Stimulus file has more than %0d steps", maxSteps);
                fileErrors++;
                break;
            end
            n = $sscanf(line, "%b %b %b %b %h %h %b %h %h %b",
                        sel, load, drive, mem, op, data, mask, eBus, eOut, eBranch);
            if (n != 10) begin
                $display("Malformed stimulus line, skipped: %s", line);
                fileErrors++;
            end else begin
                selVec[stepCount]    = sel;
                loadVec[stepCount]   = load;
                driveVec[stepCount]  = drive;
                memVec[stepCount]    = mem;
                opVec[stepCount]     = op;
                dataVec[stepCount]   = data;
                maskVec[stepCount]   = mask;
                expBus[stepCount]    = eBus;
                expOut[stepCount]    = eOut;
                expBranch[stepCount] = eBranch;
                stepCount++;
            end
        end
        $fclose(fd);
        if (stepCount == 0) begin
            $display("No control steps were read from the stimulus file");
            fileErrors++;
        end
    endtask

    initial begin
        clk  = 1'b0;
        rstN = 1'b0;
        clearInputs();
        loadStimulus();
        cycleLimit = stepCount + 20;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        for (int s = 0; s < stepCount; s++) begin
            applyStep(s);
            #1;  // Bus settles within the cycle
            if (maskVec[s][2] && busValue !== expBus[s]) begin
                $display("CHECK FAILED at %0t ns: step %0d busValue %h, expected %h",
                         $time, s + 1, busValue, expBus[s]);
                checkErrors++;
            end
            @(posedge clk);
            #1;
            if (maskVec[s][1] && outPortData !== expOut[s]) begin
                $display("CHECK FAILED at %0t ns: step %0d outPortData %h, expected %h",
                         $time, s + 1, outPortData, expOut[s]);
                checkErrors++;
            end
            if (maskVec[s][0] && branchTaken !== expBranch[s]) begin
                $display("CHECK FAILED at %0t ns: step %0d branchTaken %b, expected %b",
                         $time, s + 1, branchTaken, expBranch[s]);
                checkErrors++;
            end
            @(negedge clk);
        end
        clearInputs();
        $display("Errors: %0d check failures, %0d stimulus file problems",
                 checkErrors, fileErrors);
        if (checkErrors == 0 && fileErrors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* dv/datapathStimulus.txt */
# sel: gra grb grc rIn rOut baOut | load: hiIn loIn zIn pcIn irIn yIn marIn mdrIn outPortIn inPortIn conIn
# drive: hiOut loOut zHighOut zLowOut pcOut mdrOut inPortOut cOut | mem: memRead memWrite
# sel load drive mem opcode inData mask(bus out branch) expBus expOut expBranch
000000 00000000010 00000000 00 00 02800000 011 00000000 00000000 0
000000 00001000010 00000010 00 00 1234abcd 100 02800000 00000000 0
100100 00000000010 00000010 00 00 deadbeef 100 1234abcd 00000000 0
100010 00000000000 00000000 00 00 00000000 100 1234abcd 00000000 0
010100 00000000010 00000010 00 00 80000f01 100 deadbeef 00000000 0
010010 00000000000 00000000 00 00 00000000 100 deadbeef 00000000 0
010001 00000000000 00000000 00 00 00000000 100 00000000 00000000 0
100001 00000000000 00000000 00 00 00000000 100 1234abcd 00000000 0
000000 00000100010 00000010 00 00 00000010 100 80000f01 00000000 0
000000 00100000010 00000010 00 03 00000010 100 00000010 00000000 0
000000 00000000000 00010000 00 00 00000000 100 80000f11 00000000 0
000000 00100000010 00000010 00 04 00000004 100 00000010 00000000 0
000000 00000000000 00010000 00 00 00000000 100 80000ef1 00000000 0
000000 00100000010 00000010 00 05 00000004 100 00000004 00000000 0
000000 00000000000 00010000 00 00 00000000 100 080000f0 00000000 0
000000 00100000010 00000010 00 06 00000004 100 00000004 00000000 0
000000 00000000000 00010000 00 00 00000000 100 f80000f0 00000000 0
000000 00100000010 00000010 00 07 00000004 100 00000004 00000000 0
000000 00000000000 00010000 00 00 00000000 100 0000f010 00000000 0
000000 00100000010 00000010 00 08 00000004 100 00000004 00000000 0
000000 00000000000 00010000 00 00 00000000 100 180000f0 00000000 0
000000 00100000010 00000010 00 09 00000010 100 00000004 00000000 0
000000 00000000000 00010000 00 00 00000000 100 0000f018 00000000 0
000000 00100000010 00000010 00 11 00000010 100 00000010 00000000 0
000000 00000000000 00010000 00 00 00000000 100 fffffff0 00000000 0
000000 00100000010 00000010 00 12 00000002 100 00000010 00000000 0
000000 00000000000 00010000 00 00 00000000 100 ffffffef 00000000 0
000000 00100000010 00000010 00 0f 00000064 100 00000002 00000000 0
000000 00000000000 00010000 00 00 00000000 100 00001e02 00000000 0
000000 00000000000 00100000 00 00 00000000 100 ffffffff 00000000 0
000000 00000100010 00000010 00 00 00000007 100 00000064 00000000 0
000000 00100000010 00000010 00 10 00000000 100 00000007 00000000 0
000000 00000000000 00010000 00 00 00000000 100 0000000e 00000000 0
000000 00000000000 00100000 00 00 00000000 100 00000002 00000000 0
000000 00100000010 00000010 00 10 000001a5 100 00000000 00000000 0
000000 00000000000 00010000 00 00 00000000 100 ffffffff 00000000 0
000000 00000000000 00100000 00 00 00000000 100 00000064 00000000 0
000000 00000010010 00000010 00 00 5a5a1234 100 000001a5 00000000 0
000000 00000001010 00000010 00 00 00000000 100 5a5a1234 00000000 0
000000 00000000000 00000000 01 00 00000000 000 00000000 00000000 0
000000 00000001010 00000010 00 00 00040005 100 00000000 00000000 0
000000 00000001000 00000000 10 00 00000000 000 00000000 00000000 0
000000 00000000000 00000100 00 00 00000000 100 5a5a1234 00000000 0
000000 00001000010 00000010 00 00 02800000 100 00040005 00000000 0
000000 00000000100 00000001 00 00 00000000 110 fffc0005 fffc0005 0
000000 00001000010 00000010 00 00 02880000 100 02800000 fffc0005 0
000000 00000000001 00000000 00 00 00000000 111 00000000 fffc0005 1
000000 00000000001 00100000 00 00 00000000 111 00000064 fffc0005 0
000000 00000000001 00010000 00 00 00000000 111 ffffffff fffc0005 0
000000 00001000010 00000010 00 00 02900000 100 02880000 fffc0005 0
000000 00000000001 00000000 00 00 00000000 111 00000000 fffc0005 0
000000 00000000001 00100000 00 00 00000000 111 00000064 fffc0005 1
000000 00000000001 00010000 00 00 00000000 111 ffffffff fffc0005 1
000000 00001000010 00000010 00 00 02980000 100 02900000 fffc0005 0
000000 00000000001 00000000 00 00 00000000 111 00000000 fffc0005 0
000000 00000000001 00100000 00 00 00000000 111 00000064 fffc0005 1
000000 00000000001 00010000 00 00 00000000 111 ffffffff fffc0005 0
000000 00001000000 00000010 00 00 00000000 100 02980000 fffc0005 0
000000 00000000001 00000000 00 00 00000000 111 00000000 fffc0005 0
000000 00000000001 00100000 00 00 00000000 111 00000064 fffc0005 0
000000 00000000001 00010000 00 00 00000000 111 ffffffff fffc0005 1

/* datapath.f */
src/datapathPkg.sv
src/gpRegister.sv
src/selectEncode.sv
src/busMux.sv
src/alu.sv
src/branchCondition.sv
src/memoryPort.sv
src/datapath.sv
dv/datapathTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= datapathTb
FILELIST  ?= datapath.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= TEST PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
